//--- Bender.yml
package:
  name: cpu

export_include_dirs:
  - include

sources:
  - verilog/rv32i_types_pkg.sv
  - verilog/pipe_pkg.sv
  - verilog/regfile_if.sv
  - verilog/stall.sv
  - verilog/fetch_stage.sv
  - verilog/decode_stage.sv
  - verilog/execute_stage.sv
  - verilog/memory_stage.sv
  - verilog/cpu.sv
  - target: test
    files:
      - verification/cpu_checker.sv
      - verification/tb_cpu.sv

//--- cpu.f
+incdir+include
verilog/rv32i_types_pkg.sv
verilog/pipe_pkg.sv
verilog/regfile_if.sv
verilog/stall.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/cpu.sv
verification/cpu_checker.sv
verification/tb_cpu.sv

//--- include/cpu_macros.svh
// --------------------
// word width, register count, reset address and the NOP encoding.
// --------------------
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define XLEN 32
`define NUM_REGS 32
`define RESET_PC 32'h0000_0000

// addi x0, x0, 0.
`define NOP_INSN 32'h0000_0013

`endif

//--- verification/cpu_checker.sv
// --------------------
// ISA reference model of the program, port monitor and result reporting.
// --------------------
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_checker #(
    parameter int PROG_LEN   = 64,
    parameter int DATA_WORDS = 16
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        prog_ready,
    input  logic [31:0] prog [PROG_LEN],
    input  logic [31:0] init_data [DATA_WORDS],
    input  logic [31:0] imem_addr,
    input  logic [3:0]  imem_rmask,
    input  logic [31:0] dmem_addr,
    input  logic [3:0]  dmem_rmask,
    input  logic [3:0]  dmem_wmask,
    input  logic [31:0] dmem_wdata,
    input  logic        dmem_resp,
    input  logic        wb_we,
    input  logic [4:0]  wb_rd,
    input  logic [31:0] wb_data,
    output logic        done
);

    localparam int T_RESET = 0;
    localparam int T_FETCH = 1;
    localparam int T_WB    = 2;
    localparam int T_STORE = 3;
    localparam int T_COUNT = 4;

    int          checks [5];
    int          fails [5];
    logic [4:0]  exp_rd [$];   // expected register writes, in program order.
    logic [31:0] exp_val [$];
    logic [31:0] exp_addr [$]; // expected stores.
    logic [31:0] exp_data [$];
    int          n_wr;
    int          n_st;
    int          seen_wr;
    int          seen_st;
    int          rst_cycles;
    logic        released   = 1'b0;
    logic        fetch_seen = 1'b0;
    logic        built      = 1'b0;
    logic        drained    = 1'b0;

    assign done = built && drained;

    function automatic string test_name(int t);
        case (t)
            T_RESET: return "reset";
            T_FETCH: return "first fetch";
            T_WB:    return "writeback";
            T_STORE: return "store";
            default: return "count";
        endcase
    endfunction

    function automatic logic [31:0] isa_alu(logic [2:0] f3, logic alt,
                                            logic [31:0] a, logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << sh;
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) return $signed(a) >>> sh;
                else return a >> sh;
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic build_model();
        logic [31:0] regs [32];
        logic [31:0] mem [DATA_WORDS];
        logic [31:0] insn;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] addr;
        logic [31:0] val;
        logic [2:0]  f3;
        int          i;
        for (i = 0; i < 32; i++) regs[i] = '0;
        for (i = 0; i < DATA_WORDS; i++) mem[i] = init_data[i];
        for (i = 0; i < PROG_LEN; i++) begin
            insn  = prog[i];
            f3    = insn[14:12];
            a     = regs[insn[19:15]];
            b     = regs[insn[24:20]];
            imm_i = {{20{insn[31]}}, insn[31:20]};
            val   = '0;
            case (insn[6:0])
                7'b0110111: val = {insn[31:12], 12'h000};
                7'b0010011: val = isa_alu(f3, f3 == 3'd5 && insn[30], a, imm_i);
                7'b0110011: val = isa_alu(f3, insn[30], a, b);
                7'b0000011: begin
                    addr = a + imm_i;
                    val  = mem[(addr >> 2) % DATA_WORDS];
                end
                default: begin
                    addr = a + {{20{insn[31]}}, insn[31:25], insn[11:7]};
                    mem[(addr >> 2) % DATA_WORDS] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
            endcase
            if (insn[6:0] != 7'b0100011) begin
                exp_rd.push_back(insn[11:7]);
                exp_val.push_back(val);
                if (insn[11:7] != 5'd0) regs[insn[11:7]] = val; // x0 stays zero.
            end
        end
        n_wr = exp_rd.size();
        n_st = exp_addr.size();
    endtask

    task automatic compare(int t, logic [31:0] expected, logic [31:0] actual);
        checks[t]++;
        if (actual !== expected) begin
            fails[t]++;
            $display("FAIL %s: expected %h, actual %h", test_name(t), expected, actual);
        end
    endtask

    task automatic print_test(int t);
        $display("test %s: %0d checks, %0d failures", test_name(t), checks[t], fails[t]);
    endtask

    task automatic check_write();
        if (exp_rd.size() == 0) begin
            // trailing nops write x0 with zero.
            if (wb_rd != 5'd0 || wb_data != 32'd0) begin
                fails[T_WB]++;
                $display("register write to x%0d came after the program ended", wb_rd);
            end
        end else begin
            compare(T_WB, {27'd0, exp_rd.pop_front()}, {27'd0, wb_rd});
            compare(T_WB, exp_val.pop_front(), wb_data);
            seen_wr++;
        end
    endtask

    task automatic check_store();
        if (exp_addr.size() == 0) begin
            fails[T_STORE]++;
            $display("store to address %h came after the program ended", dmem_addr);
        end else begin
            compare(T_STORE, exp_addr.pop_front(), dmem_addr);
            compare(T_STORE, exp_data.pop_front(), dmem_wdata);
            compare(T_STORE, 32'hf, {28'd0, dmem_wmask});
            seen_st++;
        end
    endtask

    task automatic report(output int total_fail);
        int total_chk;
        int t;
        compare(T_COUNT, n_wr, seen_wr);
        compare(T_COUNT, n_st, seen_st);
        print_test(T_WB);
        print_test(T_STORE);
        print_test(T_COUNT);
        total_chk  = 0;
        total_fail = 0;
        for (t = 0; t <= T_COUNT; t++) begin
            total_chk  += checks[t];
            total_fail += fails[t];
        end
        $display("%0d tests, %0d checks, %0d failures", T_COUNT + 1, total_chk, total_fail);
    endtask

    initial begin
        wait (prog_ready === 1'b1);
        build_model();
        built = 1'b1;
    end

    // --------------------
    // port monitor.
    // --------------------
    always @(posedge clk) begin
        if (!rst_n) begin
            // the first edge of reset is the one that clears the state.
            if (rst_cycles > 0) compare(T_RESET, 32'd0, {23'd0, wb_we, dmem_rmask, dmem_wmask});
            rst_cycles++;
        end else begin
            if (!released) begin
                compare(T_RESET, 32'd0, {23'd0, wb_we, dmem_rmask, dmem_wmask});
                released = 1'b1;
                print_test(T_RESET);
            end
            if (!fetch_seen && imem_rmask != 4'h0) begin
                compare(T_FETCH, `RESET_PC, imem_addr);
                fetch_seen = 1'b1;
                print_test(T_FETCH);
            end
            // this fetch is raised only after the last program instruction has written back.
            if (imem_rmask != 4'h0 && imem_addr >= 32'((PROG_LEN + 4) * 4)) drained = 1'b1;
            if (wb_we) check_write();
            if (dmem_wmask != 4'h0 && dmem_resp) check_store(); // a store counts at its resp.
        end
    end

endmodule

//--- verification/tb_cpu.sv
// --------------------
// testbench top: clock, reset, program generator, memory models and watchdog.
// --------------------
`timescale 1ns/1ps
`include "cpu_macros.svh"

module tb_cpu;

    localparam int PROG_LEN    = 64;
    localparam int DATA_WORDS  = 16;
    localparam int WATCHDOG_NS = (PROG_LEN + 8) * 5 * 4 * 100;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [3:0]  imem_rmask;
    logic [31:0] imem_rdata;
    logic        imem_resp;
    logic [31:0] dmem_addr;
    logic [3:0]  dmem_rmask;
    logic [3:0]  dmem_wmask;
    logic [31:0] dmem_wdata;
    logic [31:0] dmem_rdata;
    logic        dmem_resp;
    logic        wb_we;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    logic [31:0] prog [PROG_LEN];
    logic [31:0] init_data [DATA_WORDS];
    logic [31:0] dmem [DATA_WORDS];
    logic [4:0]  recent [3];   // destinations of the last three instructions.
    logic [31:0] seed;
    logic        prog_ready;
    logic        done;
    logic        i_busy;
    logic        d_busy;
    int          i_wait;
    int          d_wait;
    int          failures;

    cpu DUT (
        .clk, .rst_n, .imem_addr, .imem_rmask, .imem_rdata, .imem_resp,
        .dmem_addr, .dmem_rmask, .dmem_wmask, .dmem_wdata, .dmem_rdata, .dmem_resp,
        .wb_we, .wb_rd, .wb_data
    );

    cpu_checker #(.PROG_LEN(PROG_LEN), .DATA_WORDS(DATA_WORDS)) chk (
        .clk, .rst_n, .prog_ready, .prog, .init_data, .imem_addr, .imem_rmask,
        .dmem_addr, .dmem_rmask, .dmem_wmask, .dmem_wdata, .dmem_resp,
        .wb_we, .wb_rd, .wb_data, .done
    );

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int unsigned rand_below(int unsigned n);
        logic [31:0] r;
        r = next_rand();
        return r[31:16] % n; // the high bits of the generator mix best.
    endfunction

    function automatic logic [4:0] pick_src();
        logic [4:0] r;
        do begin
            r = 5'(rand_below(32));
        end while (r != 5'd0 && (r == recent[0] || r == recent[1] || r == recent[2]));
        return r;
    endfunction

    function automatic logic [31:0] insn_at(logic [31:0] addr);
        if (addr[31:2] < PROG_LEN) return prog[addr[31:2]];
        return `NOP_INSN;
    endfunction

    task automatic build_program();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [11:0] off;
        logic        alt;
        int          kind;
        int          i;
        for (i = 0; i < 3; i++) recent[i] = 5'd0;
        for (i = 0; i < PROG_LEN; i++) begin
            kind = rand_below(8);
            rd   = (rand_below(8) == 0) ? 5'd0 : 5'(rand_below(32));
            rs1  = pick_src();
            rs2  = pick_src();
            f3   = 3'(rand_below(8));
            alt  = rand_below(2) == 1;
            imm  = 12'(rand_below(4096));
            off  = {6'd0, 4'(rand_below(DATA_WORDS)), 2'b00}; // word aligned, base x0.
            case (kind)
                0: prog[i] = {imm, 8'(rand_below(256)), rd, 7'b0110111};
                1, 2: begin
                    if (f3 == 3'd1) imm = {7'd0, imm[4:0]};
                    if (f3 == 3'd5) imm = {1'b0, alt, 5'd0, imm[4:0]};
                    prog[i] = {imm, rs1, f3, rd, 7'b0010011};
                end
                3, 4: begin
                    alt     = alt && (f3 == 3'd0 || f3 == 3'd5);
                    prog[i] = {1'b0, alt, 5'd0, rs2, rs1, f3, rd, 7'b0110011};
                end
                5: prog[i] = {off, 5'd0, 3'b010, rd, 7'b0000011};
                default: begin
                    prog[i] = {off[11:5], rs2, 5'd0, 3'b010, off[4:0], 7'b0100011};
                    rd      = 5'd0; // stores write no register.
                end
            endcase
            recent[2] = recent[1];
            recent[1] = recent[0];
            recent[0] = rd;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // --------------------
    // memory models, both answered on the falling edge.
    // --------------------
    always @(negedge clk) begin
        imem_resp = 1'b0;
        dmem_resp = 1'b0;
        if (!rst_n) begin
            i_busy = 1'b0;
            d_busy = 1'b0;
        end else begin
            if (imem_rmask != 4'h0) begin
                if (!i_busy) begin
                    i_busy = 1'b1;
                    i_wait = rand_below(4);
                end
                if (i_wait == 0) begin
                    imem_rdata = insn_at(imem_addr);
                    imem_resp  = 1'b1;
                    i_busy     = 1'b0;
                end else begin
                    i_wait--;
                end
            end
            if (dmem_rmask != 4'h0 || dmem_wmask != 4'h0) begin
                if (!d_busy) begin
                    d_busy = 1'b1;
                    d_wait = rand_below(4);
                end
                if (d_wait == 0) begin
                    if (dmem_wmask != 4'h0) dmem[(dmem_addr >> 2) % DATA_WORDS] = dmem_wdata;
                    else dmem_rdata = dmem[(dmem_addr >> 2) % DATA_WORDS];
                    dmem_resp = 1'b1;
                    d_busy    = 1'b0;
                end else begin
                    d_wait--;
                end
            end
        end
    end

    initial begin
        rst_n      = 1'b0;
        imem_rdata = '0;
        imem_resp  = 1'b0;
        dmem_rdata = '0;
        dmem_resp  = 1'b0;
        prog_ready = 1'b0;
        i_busy     = 1'b0;
        d_busy     = 1'b0;
        i_wait     = 0;
        d_wait     = 0;
        seed       = 32'd45;
        build_program();
        for (int w = 0; w < DATA_WORDS; w++) begin
            init_data[w] = next_rand();
            dmem[w]      = init_data[w];
        end
        prog_ready = 1'b1;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        wait (done === 1'b1);
        repeat (8) @(posedge clk); // trailing nops pass through the monitor.
        chk.report(failures);
        if (failures == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the program did not retire within %0d ns", WATCHDOG_NS);
        $display("Verification failed");
        $finish;
    end

endmodule

//--- verilog/cpu.sv
// --------------------
// pipeline top: stages, stall unit and register file port bundle.
// --------------------
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu import pipe_pkg::*; (
    input  logic                         clk,
    input  logic                         rst_n,

    output logic [`XLEN-1:0]             imem_addr,
    output logic [3:0]                   imem_rmask,
    input  logic [`XLEN-1:0]             imem_rdata,
    input  logic                         imem_resp,

    output logic [`XLEN-1:0]             dmem_addr,
    output logic [3:0]                   dmem_rmask,
    output logic [3:0]                   dmem_wmask,
    output logic [`XLEN-1:0]             dmem_wdata,
    input  logic [`XLEN-1:0]             dmem_rdata,
    input  logic                         dmem_resp,

    output logic                         wb_we,
    output logic [$clog2(`NUM_REGS)-1:0] wb_rd,
    output logic [`XLEN-1:0]             wb_data
);

    logic    move;
    logic    imem_req;
    logic    dmem_req;
    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;

    regfile_if rf ();

    stall u_stall (.clk, .rst_n, .imem_req, .dmem_req, .imem_resp, .dmem_resp, .move);

    fetch_stage u_fetch (
        .clk, .rst_n, .move, .imem_resp, .imem_addr, .imem_rmask, .imem_req, .if_id
    );

    decode_stage u_decode (
        .clk, .rst_n, .move, .imem_rdata, .imem_resp,
        .if_id, .id_ex, .rf(rf.reader), .rf_own(rf.owner)
    );

    execute_stage u_execute (.clk, .rst_n, .move, .id_ex, .ex_mem);

    memory_stage u_memory (
        .clk, .rst_n, .move, .dmem_rdata, .dmem_resp, .ex_mem,
        .dmem_addr, .dmem_wdata, .dmem_rmask, .dmem_wmask, .dmem_req, .rf(rf.writer)
    );

    // writeback port, visible outside for checking.
    assign wb_we   = rf.we;
    assign wb_rd   = rf.rd_s;
    assign wb_data = rf.rd_v;

endmodule

//--- verilog/decode_stage.sv
// --------------------
// instruction capture, decoder, immediates and the register file.
// --------------------
`timescale 1ns/1ps
`include "cpu_macros.svh"

module decode_stage import rv32i_types_pkg::*; import pipe_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              move,
    input  logic [`XLEN-1:0]  imem_rdata,
    input  logic              imem_resp,
    input  if_id_t            if_id,
    output id_ex_t            id_ex,
    regfile_if.reader         rf,
    regfile_if.owner          rf_own
);

    word_t     fetch_buf; // word that arrived before move.
    logic      buf_full;
    word_t     insn;
    logic      insn_ok;
    opcode_t   opc;
    arith_f3_t f3;
    id_ex_t    dec;
    word_t     regs [`NUM_REGS];

    function automatic alu_op_t arith_op(arith_f3_t f, logic alt);
        case (f)
            f3_add:  return alt ? alu_sub : alu_add;
            f3_sll:  return alu_sll;
            f3_slt:  return alu_slt;
            f3_sltu: return alu_sltu;
            f3_xor:  return alu_xor;
            f3_sr:   return alt ? alu_sra : alu_srl;
            f3_or:   return alu_or;
            default: return alu_and;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (imem_resp) fetch_buf <= imem_rdata;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            buf_full <= 1'b0;
            insn_ok  <= 1'b0;
            insn     <= `NOP_INSN;
        end else if (move) begin
            buf_full <= 1'b0;
            insn_ok  <= imem_resp | buf_full;
            insn     <= imem_resp ? imem_rdata : fetch_buf;
        end else if (imem_resp) begin
            buf_full <= 1'b1;
        end
    end

    assign opc      = opcode_t'(insn[6:0]);
    assign f3       = arith_f3_t'(insn[14:12]);
    assign rf.rs1_s = insn[19:15];
    assign rf.rs2_s = insn[24:20];

    always_comb begin
        dec       = '0;
        dec.rs1_v = rf.rs1_v;
        dec.rs2_v = rf.rs2_v;
        dec.rd    = insn[11:7];
        dec.imm   = {{20{insn[31]}}, insn[31:20]}; // I format by default.
        case (opc)
            op_lui: begin
                dec.valid   = 1'b1;
                dec.alu_op  = alu_pass_b;
                dec.imm     = {insn[31:12], 12'b0};
                dec.use_imm = 1'b1;
                dec.reg_we  = 1'b1;
            end
            op_imm: begin
                dec.valid   = 1'b1;
                dec.alu_op  = arith_op(f3, insn[30] && f3 == f3_sr);
                dec.use_imm = 1'b1;
                dec.reg_we  = 1'b1;
            end
            op_reg: begin
                dec.valid   = 1'b1;
                dec.alu_op  = arith_op(f3, insn[30]);
                dec.reg_we  = 1'b1;
            end
            op_load: begin
                dec.valid    = insn[14:12] == 3'b010; // word access only.
                dec.alu_op   = alu_add;
                dec.use_imm  = 1'b1;
                dec.reg_we   = 1'b1;
                dec.mem_read = 1'b1;
            end
            op_store: begin
                dec.valid     = insn[14:12] == 3'b010;
                dec.alu_op    = alu_add;
                dec.imm       = {{20{insn[31]}}, insn[31:25], insn[11:7]};
                dec.use_imm   = 1'b1;
                dec.mem_write = 1'b1;
            end
            default: ; // unsupported opcodes leave a bubble.
        endcase
        // no exceptions, so a misaligned pc also becomes a bubble.
        dec.valid = dec.valid & insn_ok & (if_id.pc[1:0] == 2'b00);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) id_ex.valid <= 1'b0;
        else if (move) id_ex <= dec;
    end

    // --------------------
    // register file with write-through reads.
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) regs[i] <= '0;
        end else if (rf_own.we && rf_own.rd_s != '0) begin
            regs[rf_own.rd_s] <= rf_own.rd_v;
        end
    end

    assign rf_own.rs1_v = (rf_own.we && rf_own.rd_s == rf_own.rs1_s && rf_own.rs1_s != '0) ?
                          rf_own.rd_v : regs[rf_own.rs1_s];
    assign rf_own.rs2_v = (rf_own.we && rf_own.rd_s == rf_own.rs2_s && rf_own.rs2_s != '0) ?
                          rf_own.rd_v : regs[rf_own.rs2_s];

endmodule

//--- verilog/execute_stage.sv
// --------------------
// ALU and load/store address generation.
// --------------------
`timescale 1ns/1ps
`include "cpu_macros.svh"

module execute_stage import rv32i_types_pkg::*; import pipe_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    move,
    input  id_ex_t  id_ex,
    output ex_mem_t ex_mem
);

    word_t      a;
    word_t      b;
    word_t      y;
    logic [4:0] shamt;

    assign a     = id_ex.rs1_v;
    assign b     = id_ex.use_imm ? id_ex.imm : id_ex.rs2_v;
    assign shamt = b[4:0];

    always_comb begin
        case (id_ex.alu_op)
            alu_add:    y = a + b;       // also the load/store address.
            alu_sub:    y = a - b;
            alu_sll:    y = a << shamt;
            alu_slt:    y = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu:   y = {{(`XLEN-1){1'b0}}, a < b};
            alu_xor:    y = a ^ b;
            alu_srl:    y = a >> shamt;
            alu_sra:    y = word_t'($signed(a) >>> shamt);
            alu_or:     y = a | b;
            alu_and:    y = a & b;
            alu_pass_b: y = b;           // lui.
            default:    y = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem.valid <= 1'b0;
        end else if (move) begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.alu_result <= y;
            ex_mem.store_data <= id_ex.rs2_v;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.reg_we     <= id_ex.reg_we;
            ex_mem.mem_read   <= id_ex.mem_read;
            ex_mem.mem_write  <= id_ex.mem_write;
        end
    end

endmodule

//--- verilog/fetch_stage.sv
// --------------------
// program counter and instruction fetch request.
// --------------------
`timescale 1ns/1ps
`include "cpu_macros.svh"

module fetch_stage import pipe_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              move,
    input  logic              imem_resp,
    output logic [`XLEN-1:0]  imem_addr,
    output logic [3:0]        imem_rmask,
    output logic              imem_req,
    output if_id_t            if_id
);

    logic [`XLEN-1:0] pc;
    logic             started;   // low only in the cycle after reset.
    logic             have_insn; // response already seen for this pc.

    assign imem_req   = started & ~have_insn;
    assign imem_addr  = pc;
    assign imem_rmask = imem_req ? 4'hf : 4'h0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc        <= `RESET_PC;
            started   <= 1'b0;
            have_insn <= 1'b0;
        end else begin
            started <= 1'b1;
            if (move && started) begin
                pc        <= pc + `XLEN'(4);
                have_insn <= 1'b0;
            end else if (imem_resp) begin
                have_insn <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (move && started) if_id.pc <= pc;
    end

endmodule

//--- verilog/memory_stage.sv
// --------------------
// data memory access, load capture and register writeback.
// --------------------
`timescale 1ns/1ps
`include "cpu_macros.svh"

module memory_stage import pipe_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              move,
    input  logic [`XLEN-1:0]  dmem_rdata,
    input  logic              dmem_resp,
    input  ex_mem_t           ex_mem,
    output logic [`XLEN-1:0]  dmem_addr,
    output logic [`XLEN-1:0]  dmem_wdata,
    output logic [3:0]        dmem_rmask,
    output logic [3:0]        dmem_wmask,
    output logic              dmem_req,
    regfile_if.writer         rf
);

    logic             is_mem;
    logic             got_resp;
    logic [`XLEN-1:0] ld_buf;   // load word that arrived before move.
    logic [`XLEN-1:0] ld_data;
    mem_wb_t          mem_wb;

    assign is_mem     = ex_mem.valid & (ex_mem.mem_read | ex_mem.mem_write);
    assign dmem_req   = is_mem & ~got_resp;
    assign dmem_addr  = ex_mem.alu_result;
    assign dmem_wdata = ex_mem.store_data;
    assign dmem_rmask = (dmem_req & ex_mem.mem_read) ? 4'hf : 4'h0;
    assign dmem_wmask = (dmem_req & ex_mem.mem_write) ? 4'hf : 4'h0;

    always_ff @(posedge clk) begin
        if (!rst_n) got_resp <= 1'b0;
        else if (move) got_resp <= 1'b0;
        else if (dmem_resp) got_resp <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (dmem_resp) ld_buf <= dmem_rdata;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_wb.valid <= 1'b0;
        end else if (move) begin
            mem_wb.valid   <= ex_mem.valid;
            mem_wb.result  <= ex_mem.alu_result;
            mem_wb.rd      <= ex_mem.rd;
            mem_wb.reg_we  <= ex_mem.reg_we;
            mem_wb.is_load <= ex_mem.mem_read;
            ld_data        <= dmem_resp ? dmem_rdata : ld_buf;
        end
    end

    // the write lands once, in the cycle the instruction leaves writeback.
    assign rf.we   = mem_wb.valid & mem_wb.reg_we & move;
    assign rf.rd_s = mem_wb.rd;
    assign rf.rd_v = mem_wb.is_load ? ld_data : mem_wb.result;

endmodule

//--- verilog/pipe_pkg.sv
// --------------------
// pipeline stage register structs.
// --------------------
package pipe_pkg;

    import rv32i_types_pkg::*;

    typedef struct packed {
        word_t    pc;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        alu_op_t  alu_op;
        word_t    rs1_v;
        word_t    rs2_v;
        word_t    imm;
        logic     use_imm;   // operand b comes from the immediate.
        reg_idx_t rd;
        logic     reg_we;
        logic     mem_read;
        logic     mem_write;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        word_t    alu_result;
        word_t    store_data;
        reg_idx_t rd;
        logic     reg_we;
        logic     mem_read;
        logic     mem_write;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        word_t    result;
        reg_idx_t rd;
        logic     reg_we;
        logic     is_load;
    } mem_wb_t;

endpackage

//--- verilog/regfile_if.sv
// --------------------
// register file read and write port bundle.
// --------------------
`timescale 1ns/1ps

interface regfile_if import rv32i_types_pkg::*; ();

    reg_idx_t rs1_s;
    reg_idx_t rs2_s;
    word_t    rs1_v;
    word_t    rs2_v;
    logic     we;
    reg_idx_t rd_s;
    word_t    rd_v;

    modport reader (output rs1_s, rs2_s, input rs1_v, rs2_v);
    modport writer (output we, rd_s, rd_v);
    modport owner  (input rs1_s, rs2_s, we, rd_s, rd_v, output rs1_v, rs2_v);

endinterface

//--- verilog/rv32i_types_pkg.sv
// --------------------
// ISA level types: words, register indices, opcodes, funct3 and ALU ops.
// --------------------
`include "cpu_macros.svh"

package rv32i_types_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011
    } opcode_t;

    typedef enum logic [2:0] {
        f3_add  = 3'b000,
        f3_sll  = 3'b001,
        f3_slt  = 3'b010,
        f3_sltu = 3'b011,
        f3_xor  = 3'b100,
        f3_sr   = 3'b101, // srl or sra, chosen by bit 30.
        f3_or   = 3'b110,
        f3_and  = 3'b111
    } arith_f3_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_t;

endpackage

//--- verilog/stall.sv
// --------------------
// global advance strobe from the memory request state.
// --------------------
`timescale 1ns/1ps

module stall (
    input  logic clk,
    input  logic rst_n,
    input  logic imem_req,
    input  logic dmem_req,
    input  logic imem_resp,
    input  logic dmem_resp,
    output logic move
);

    logic imem_done;
    logic dmem_done;
    logic imem_ok;
    logic dmem_ok;

    // a side is satisfied if idle, answered now, or answered earlier.
    assign imem_ok = ~imem_req | imem_resp | imem_done;
    assign dmem_ok = ~dmem_req | dmem_resp | dmem_done;
    assign move    = imem_ok & dmem_ok;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            imem_done <= 1'b0;
            dmem_done <= 1'b0;
        end else if (move) begin
            imem_done <= 1'b0;
            dmem_done <= 1'b0;
        end else begin
            if (imem_resp) imem_done <= 1'b1;
            if (dmem_resp) dmem_done <= 1'b1;
        end
    end

endmodule
